// File: commit_pkg.sv
`default_nettype none

package commit_pkg;

	// widths of the retire/commit stream
	typedef logic [63:0] addr_t; // program counter
	typedef logic [31:0] inst_t; // instruction word
	typedef logic [63:0] data_t; // write-back data
	typedef logic [4:0]  reg_idx_t; // x0..x31

	// decode and status fields
	typedef logic [6:0]  opcode_t; // inst[6:0]
	typedef logic [7:0]  trap_code_t; // low byte of a0
	typedef logic [63:0] count_t; // cycle and instr counters

	// integer register file size
	localparam int NUM_REGS = 32;

	// custom halt instruction, opcode 0x6b
	localparam opcode_t TRAP_OPCODE = 7'h6b;

	// a0 holds the program result when the trap is taken
	localparam reg_idx_t RESULT_REG = 5'd10;

endpackage

`default_nettype wire

// File: commit_capture.sv
`timescale 1ns/1ns
`default_nettype none

module commit_capture import commit_pkg::*; (
	input  logic     clock,
	input  logic     reset,

	input  logic     retire_valid,
	input  addr_t    retire_pc,
	input  inst_t    retire_inst,
	input  logic     retire_wen,
	input  reg_idx_t retire_rdest,
	input  data_t    retire_wdata,
	output logic     retire_ready,

	output logic     cap_valid,
	output addr_t    cap_pc,
	output inst_t    cap_inst,
	output logic     cap_wen,
	output reg_idx_t cap_rdest,
	output data_t    cap_wdata,
	input  logic     cap_ready
);

	logic accept;
	logic bubble;

	assign bubble = (retire_inst == '0); // all-zero word is a pipeline bubble
	assign retire_ready = !cap_valid || cap_ready; // empty or draining this cycle
	assign accept = retire_valid && retire_ready;

	always_ff @(posedge clock) begin
		if (reset) begin
			cap_valid <= 1'b0;
		end else if (accept) begin
			cap_valid <= !bubble; // bubble taken but not kept
		end else if (cap_ready) begin
			cap_valid <= 1'b0;
		end
	end

	// payload only loads real instructions
	always_ff @(posedge clock) begin
		if (accept && !bubble) begin
			cap_pc    <= retire_pc;
			cap_inst  <= retire_inst;
			cap_wen   <= retire_wen;
			cap_rdest <= retire_rdest;
			cap_wdata <= retire_wdata;
		end
	end

endmodule

`default_nettype wire

// File: commit_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module commit_fifo import commit_pkg::*; #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic     clock,
	input  logic     reset,

	input  logic     in_valid,
	input  addr_t    in_pc,
	input  inst_t    in_inst,
	input  logic     in_wen,
	input  reg_idx_t in_rdest,
	input  data_t    in_wdata,
	output logic     in_ready,

	output logic     out_valid,
	output addr_t    out_pc,
	output inst_t    out_inst,
	output logic     out_wen,
	output reg_idx_t out_rdest,
	output data_t    out_wdata,
	input  logic     out_ready
);

	localparam int PTR_W = $clog2(FIFO_DEPTH);
	localparam int COUNT_W = PTR_W + 1;
	localparam logic [COUNT_W-1:0] FULL_COUNT = COUNT_W'(FIFO_DEPTH);

	addr_t    pc_mem    [FIFO_DEPTH];
	inst_t    inst_mem  [FIFO_DEPTH];
	logic     wen_mem   [FIFO_DEPTH];
	reg_idx_t rdest_mem [FIFO_DEPTH];
	data_t    wdata_mem [FIFO_DEPTH];

	logic [PTR_W-1:0]   wr_ptr;
	logic [PTR_W-1:0]   rd_ptr;
	logic [COUNT_W-1:0] count;
	logic               push;
	logic               pop;

	assign in_ready = (count != FULL_COUNT);
	assign out_valid = (count != '0);
	assign push = in_valid && in_ready;
	assign pop = out_valid && out_ready;

	// head entry straight from the storage flops
	assign out_pc    = pc_mem[rd_ptr];
	assign out_inst  = inst_mem[rd_ptr];
	assign out_wen   = wen_mem[rd_ptr];
	assign out_rdest = rdest_mem[rd_ptr];
	assign out_wdata = wdata_mem[rd_ptr];

	always_ff @(posedge clock) begin
		if (push) begin
			pc_mem[wr_ptr]    <= in_pc;
			inst_mem[wr_ptr]  <= in_inst;
			wen_mem[wr_ptr]   <= in_wen;
			rdest_mem[wr_ptr] <= in_rdest;
			wdata_mem[wr_ptr] <= in_wdata;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1; // wraps, depth is a power of two
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // idle or push and pop together
			endcase
		end
	end

endmodule

`default_nettype wire

// File: commit_tracker.sv
`timescale 1ns/1ns
`default_nettype none

module commit_tracker import commit_pkg::*; (
	input  logic       clock,
	input  logic       reset,

	input  logic       fifo_valid,
	input  addr_t      fifo_pc,
	input  inst_t      fifo_inst,
	input  logic       fifo_wen,
	input  reg_idx_t   fifo_rdest,
	input  data_t      fifo_wdata,
	output logic       fifo_ready,

	output logic       commit_valid,
	output addr_t      commit_pc,
	output inst_t      commit_inst,
	output logic       commit_wen,
	output reg_idx_t   commit_rdest,
	output data_t      commit_wdata,
	input  logic       commit_ready,

	output logic       trap_valid,
	output trap_code_t trap_code,
	output count_t     cycle_count,
	output count_t     instr_count,

	input  reg_idx_t   reg_addr,
	output data_t      reg_data
);

	typedef enum logic {
		RUNNING,
		HALTED
	} tracker_state_t;

	tracker_state_t state;
	data_t          shadow_regs [NUM_REGS];
	opcode_t        opcode;
	logic           take;
	logic           is_trap;
	logic           reg_write;

	assign opcode = fifo_inst[6:0];
	assign is_trap = (opcode == TRAP_OPCODE);

	// output slot free or being emptied, and not halted
	assign fifo_ready = (state == RUNNING) && (!commit_valid || commit_ready);
	assign take = fifo_valid && fifo_ready;
	assign reg_write = take && fifo_wen && (fifo_rdest != '0); // x0 stays zero

	assign trap_valid = (state == HALTED);
	assign reg_data = shadow_regs[reg_addr];

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= RUNNING;
		end else begin
			case (state)
				RUNNING: begin
					if (take && is_trap)
						state <= HALTED;
				end
				HALTED: state <= HALTED; // only reset leaves
				default: state <= RUNNING;
			endcase
		end
	end

	// a0 sampled before the trap's own write lands
	always_ff @(posedge clock) begin
		if (reset) begin
			trap_code <= '0;
		end else if (take && is_trap) begin
			trap_code <= shadow_regs[RESULT_REG][7:0];
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < NUM_REGS; i++)
				shadow_regs[i] <= '0;
		end else if (reg_write) begin
			shadow_regs[fifo_rdest] <= fifo_wdata;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			commit_valid <= 1'b0;
		end else if (take) begin
			commit_valid <= 1'b1;
		end else if (commit_ready) begin
			commit_valid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (take) begin
			commit_pc    <= fifo_pc;
			commit_inst  <= fifo_inst;
			commit_wen   <= fifo_wen;
			commit_rdest <= fifo_rdest;
			commit_wdata <= fifo_wdata;
		end
	end

	// both counters stop once halted
	always_ff @(posedge clock) begin
		if (reset) begin
			cycle_count <= '0;
			instr_count <= '0;
		end else if (state == RUNNING) begin
			cycle_count <= cycle_count + 1'b1;
			if (take)
				instr_count <= instr_count + 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: commit_top.sv
`timescale 1ns/1ns
`default_nettype none

module commit_top import commit_pkg::*; #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic       clock,
	input  logic       reset,

	input  logic       retire_valid,
	input  addr_t      retire_pc,
	input  inst_t      retire_inst,
	input  logic       retire_wen,
	input  reg_idx_t   retire_rdest,
	input  data_t      retire_wdata,
	output logic       retire_ready,

	output logic       commit_valid,
	output addr_t      commit_pc,
	output inst_t      commit_inst,
	output logic       commit_wen,
	output reg_idx_t   commit_rdest,
	output data_t      commit_wdata,
	input  logic       commit_ready,

	output logic       trap_valid,
	output trap_code_t trap_code,
	output count_t     cycle_count,
	output count_t     instr_count,

	input  reg_idx_t   reg_addr,
	output data_t      reg_data
);

	// capture to fifo
	logic     cap_valid;
	addr_t    cap_pc;
	inst_t    cap_inst;
	logic     cap_wen;
	reg_idx_t cap_rdest;
	data_t    cap_wdata;
	logic     cap_ready;

	// fifo to tracker
	logic     fifo_valid;
	addr_t    fifo_pc;
	inst_t    fifo_inst;
	logic     fifo_wen;
	reg_idx_t fifo_rdest;
	data_t    fifo_wdata;
	logic     fifo_ready;

	commit_capture i_commit_capture (
		.clock        (clock),
		.reset        (reset),
		.retire_valid (retire_valid),
		.retire_pc    (retire_pc),
		.retire_inst  (retire_inst),
		.retire_wen   (retire_wen),
		.retire_rdest (retire_rdest),
		.retire_wdata (retire_wdata),
		.retire_ready (retire_ready),
		.cap_valid    (cap_valid),
		.cap_pc       (cap_pc),
		.cap_inst     (cap_inst),
		.cap_wen      (cap_wen),
		.cap_rdest    (cap_rdest),
		.cap_wdata    (cap_wdata),
		.cap_ready    (cap_ready)
	);

	commit_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) i_commit_fifo (
		.clock     (clock),
		.reset     (reset),
		.in_valid  (cap_valid),
		.in_pc     (cap_pc),
		.in_inst   (cap_inst),
		.in_wen    (cap_wen),
		.in_rdest  (cap_rdest),
		.in_wdata  (cap_wdata),
		.in_ready  (cap_ready),
		.out_valid (fifo_valid),
		.out_pc    (fifo_pc),
		.out_inst  (fifo_inst),
		.out_wen   (fifo_wen),
		.out_rdest (fifo_rdest),
		.out_wdata (fifo_wdata),
		.out_ready (fifo_ready)
	);

	commit_tracker i_commit_tracker (
		.clock        (clock),
		.reset        (reset),
		.fifo_valid   (fifo_valid),
		.fifo_pc      (fifo_pc),
		.fifo_inst    (fifo_inst),
		.fifo_wen     (fifo_wen),
		.fifo_rdest   (fifo_rdest),
		.fifo_wdata   (fifo_wdata),
		.fifo_ready   (fifo_ready),
		.commit_valid (commit_valid),
		.commit_pc    (commit_pc),
		.commit_inst  (commit_inst),
		.commit_wen   (commit_wen),
		.commit_rdest (commit_rdest),
		.commit_wdata (commit_wdata),
		.commit_ready (commit_ready),
		.trap_valid   (trap_valid),
		.trap_code    (trap_code),
		.cycle_count  (cycle_count),
		.instr_count  (instr_count),
		.reg_addr     (reg_addr),
		.reg_data     (reg_data)
	);

endmodule

`default_nettype wire

// File: tb_commit_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_commit_top import commit_pkg::*; ();

	localparam int FIFO_DEPTH = 4;
	localparam int NUM_ENTRIES = 24;
	localparam int RESET_CYCLES = 16;
	localparam int TIMEOUT_CYCLES = 8 * NUM_ENTRIES + 200;

	logic       clock = 1'b0;
	logic       reset;
	logic       retire_valid;
	addr_t      retire_pc;
	inst_t      retire_inst;
	logic       retire_wen;
	reg_idx_t   retire_rdest;
	data_t      retire_wdata;
	logic       retire_ready;
	logic       commit_valid;
	addr_t      commit_pc;
	inst_t      commit_inst;
	logic       commit_wen;
	reg_idx_t   commit_rdest;
	data_t      commit_wdata;
	logic       commit_ready;
	logic       trap_valid;
	trap_code_t trap_code;
	count_t     cycle_count;
	count_t     instr_count;
	reg_idx_t   reg_addr;
	data_t      reg_data;

	// retire stimulus, one row per entry
	addr_t    stim_pc    [NUM_ENTRIES];
	inst_t    stim_inst  [NUM_ENTRIES];
	logic     stim_wen   [NUM_ENTRIES];
	reg_idx_t stim_rdest [NUM_ENTRIES];
	data_t    stim_wdata [NUM_ENTRIES];

	// reference model output
	addr_t      exp_pc    [$];
	inst_t      exp_inst  [$];
	logic       exp_wen   [$];
	reg_idx_t   exp_rdest [$];
	data_t      exp_wdata [$];
	data_t      model_regs [NUM_REGS];
	trap_code_t exp_trap_code;

	int error_count = 0;
	int check_count = 0;
	int commits_seen = 0;
	int cycles = 0;
	int run_edges = 0;

	logic     hold_check = 1'b0;
	addr_t    held_pc;
	inst_t    held_inst;
	logic     held_wen;
	reg_idx_t held_rdest;
	data_t    held_wdata;

	commit_top #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) i_commit_top (
		.clock        (clock),
		.reset        (reset),
		.retire_valid (retire_valid),
		.retire_pc    (retire_pc),
		.retire_inst  (retire_inst),
		.retire_wen   (retire_wen),
		.retire_rdest (retire_rdest),
		.retire_wdata (retire_wdata),
		.retire_ready (retire_ready),
		.commit_valid (commit_valid),
		.commit_pc    (commit_pc),
		.commit_inst  (commit_inst),
		.commit_wen   (commit_wen),
		.commit_rdest (commit_rdest),
		.commit_wdata (commit_wdata),
		.commit_ready (commit_ready),
		.trap_valid   (trap_valid),
		.trap_code    (trap_code),
		.cycle_count  (cycle_count),
		.instr_count  (instr_count),
		.reg_addr     (reg_addr),
		.reg_data     (reg_data)
	);

	always #20 clock = ~clock;

	always @(posedge clock) begin
		cycles = cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout: run still busy after %0d cycles, %0d commits seen",
				cycles, commits_seen);
			$display("test failed");
			$finish;
		end
	end

	task automatic log_error(input string msg);
		error_count++;
		$display("ERROR %0t: %s", $time, msg);
	endtask

	task automatic set_entry(input int i, input addr_t pc, input inst_t inst,
			input logic wen, input reg_idx_t rdest, input data_t wdata);
		stim_pc[i]    = pc;
		stim_inst[i]  = inst;
		stim_wen[i]   = wen;
		stim_rdest[i] = rdest;
		stim_wdata[i] = wdata;
	endtask

	task automatic load_stimulus();
		set_entry(0,  64'h1000, 32'h00500093, 1'b1, 5'd1,  64'h5);
		set_entry(1,  64'h1004, 32'h00000000, 1'b1, 5'd3,  64'hdead); // bubble
		set_entry(2,  64'h1004, 32'h00a00113, 1'b1, 5'd2,  64'ha);
		set_entry(3,  64'h1008, 32'h00000013, 1'b1, 5'd0,  64'h1234); // x0
		set_entry(4,  64'h100c, 32'h00108193, 1'b1, 5'd3,  64'h6);
		set_entry(5,  64'h1010, 32'h00000000, 1'b0, 5'd0,  64'h0);
		set_entry(6,  64'h1010, 32'h00218213, 1'b1, 5'd4,  64'hc);
		set_entry(7,  64'h1014, 32'h00100293, 1'b1, 5'd5,  64'h1);
		set_entry(8,  64'h1018, 32'h00228293, 1'b1, 5'd5,  64'h3);
		set_entry(9,  64'h101c, 32'h00328293, 1'b1, 5'd5,  64'h6);
		set_entry(10, 64'h1020, 32'h00000000, 1'b1, 5'd5,  64'hbad);
		set_entry(11, 64'h1024, 32'h00f12023, 1'b0, 5'd7,  64'h77); // store, no write
		set_entry(12, 64'h1028, 32'hfff00313, 1'b1, 5'd6,  64'hffff_ffff_ffff_ffff);
		set_entry(13, 64'h102c, 32'h00530393, 1'b1, 5'd7,  64'h4);
		set_entry(14, 64'h1030, 32'h00000000, 1'b0, 5'd0,  64'h0);
		set_entry(15, 64'h1034, 32'h12a00513, 1'b1, 5'd10, 64'h12a);
		set_entry(16, 64'h1038, 32'h00428293, 1'b1, 5'd5,  64'ha);
		set_entry(17, 64'h103c, 32'h00000013, 1'b1, 5'd0,  64'h5678);
		set_entry(18, 64'h1040, 32'h00000000, 1'b0, 5'd0,  64'h0);
		set_entry(19, 64'h1044, 32'h00150593, 1'b1, 5'd11, 64'h12b);
		set_entry(20, 64'h1048, 32'h0000006b, 1'b1, 5'd10, 64'hff); // trap
		set_entry(21, 64'h104c, 32'h00100613, 1'b1, 5'd12, 64'h1);
		set_entry(22, 64'h1050, 32'h00200693, 1'b1, 5'd13, 64'h2);
		set_entry(23, 64'h1054, 32'h00300293, 1'b1, 5'd5,  64'h3);
	endtask

	task automatic build_expected();
		logic trapped;
		trapped = 1'b0;
		exp_trap_code = '0;
		for (int r = 0; r < NUM_REGS; r++)
			model_regs[r] = '0;
		for (int i = 0; i < NUM_ENTRIES; i++) begin
			if (!trapped && stim_inst[i] != 32'h0) begin
				exp_pc.push_back(stim_pc[i]);
				exp_inst.push_back(stim_inst[i]);
				exp_wen.push_back(stim_wen[i]);
				exp_rdest.push_back(stim_rdest[i]);
				exp_wdata.push_back(stim_wdata[i]);
				if (stim_inst[i][6:0] == 7'h6b) begin
					exp_trap_code = model_regs[10][7:0]; // a0 before own write
					trapped = 1'b1;
				end
				if (stim_wen[i] && stim_rdest[i] != 5'd0)
					model_regs[stim_rdest[i]] = stim_wdata[i];
			end
		end
	endtask

	task automatic next_edge();
		@(posedge clock);
		commit_ready <= ($urandom_range(3) != 0); // stall about one cycle in four
	endtask

	task automatic present_retire(input addr_t pc, input inst_t inst, input logic wen,
			input reg_idx_t rdest, input data_t wdata);
		retire_valid <= 1'b1;
		retire_pc    <= pc;
		retire_inst  <= inst;
		retire_wen   <= wen;
		retire_rdest <= rdest;
		retire_wdata <= wdata;
	endtask

	task automatic scan_registers(input logic use_model);
		data_t expected;
		for (int r = 0; r < NUM_REGS; r++) begin
			@(posedge clock);
			reg_addr <= reg_idx_t'(r);
			@(negedge clock);
			expected = use_model ? model_regs[r] : '0;
			check_count++;
			if (reg_data !== expected)
				log_error($sformatf("x%0d reads %h, expected %h", r, reg_data, expected));
		end
	endtask

	// commit stream checker, sampled at the transfer edge
	always @(posedge clock) begin
		if (!reset) begin
			if (trap_valid !== 1'b1)
				run_edges++; // edges up to and including the trap
			if (hold_check) begin
				check_count++;
				if (commit_valid !== 1'b1 || commit_pc !== held_pc
						|| commit_inst !== held_inst || commit_wen !== held_wen
						|| commit_rdest !== held_rdest || commit_wdata !== held_wdata)
					log_error($sformatf("commit outputs moved during stall, pc %h", commit_pc));
			end
			if (commit_valid && commit_ready) begin
				check_count++;
				if (commits_seen >= exp_pc.size()) begin
					log_error($sformatf("unexpected commit pc %h inst %h",
						commit_pc, commit_inst));
				end else if (commit_pc !== exp_pc[commits_seen]
						|| commit_inst !== exp_inst[commits_seen]
						|| commit_wen !== exp_wen[commits_seen]
						|| commit_rdest !== exp_rdest[commits_seen]
						|| commit_wdata !== exp_wdata[commits_seen]) begin
					log_error($sformatf("commit %0d pc %h/%h inst %h/%h wen %b/%b rd %0d/%0d %h/%h",
						commits_seen, commit_pc, exp_pc[commits_seen],
						commit_inst, exp_inst[commits_seen], commit_wen, exp_wen[commits_seen],
						commit_rdest, exp_rdest[commits_seen],
						commit_wdata, exp_wdata[commits_seen]));
				end
				commits_seen++;
			end
			hold_check = commit_valid && !commit_ready;
			held_pc    = commit_pc;
			held_inst  = commit_inst;
			held_wen   = commit_wen;
			held_rdest = commit_rdest;
			held_wdata = commit_wdata;
		end
	end

	initial begin
		int sent;
		int fillers;
		count_t frozen_cycles;
		reset        <= 1'b1;
		retire_valid <= 1'b0;
		retire_pc    <= '0;
		retire_inst  <= '0;
		retire_wen   <= 1'b0;
		retire_rdest <= '0;
		retire_wdata <= '0;
		commit_ready <= 1'b1;
		reg_addr     <= '0;
		void'($urandom(32'hea881ed3));
		load_stimulus();
		build_expected();

		repeat (RESET_CYCLES) @(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		check_count++;
		if (commit_valid !== 1'b0 || trap_valid !== 1'b0 || retire_ready !== 1'b1)
			log_error("handshake or trap state wrong after reset");
		if (cycle_count !== '0 || instr_count !== '0 || trap_code !== '0)
			log_error($sformatf("counters not zero after reset, cycles %0d instrs %0d",
				cycle_count, instr_count));
		scan_registers(1'b0);
		check_count++;
		if (cycle_count !== count_t'(run_edges))
			log_error($sformatf("cycle_count %0d, expected %0d", cycle_count, run_edges));

		sent = 0;
		while (sent < NUM_ENTRIES) begin
			next_edge();
			if (retire_valid && retire_ready) begin
				sent++;
				retire_valid <= 1'b0;
			end
			if ((!retire_valid || retire_ready) && sent < NUM_ENTRIES
					&& $urandom_range(3) != 0)
				present_retire(stim_pc[sent], stim_inst[sent], stim_wen[sent],
					stim_rdest[sent], stim_wdata[sent]);
		end

		while (trap_valid !== 1'b1)
			next_edge();
		check_count++;
		if (trap_code !== exp_trap_code)
			log_error($sformatf("trap code %h, expected %h", trap_code, exp_trap_code));
		frozen_cycles = cycle_count;

		// keep pushing until the halted path backs up
		fillers = 0;
		repeat (FIFO_DEPTH + 4) begin
			next_edge();
			if (retire_valid && retire_ready)
				fillers++;
			present_retire(64'h2000 + 64'(4 * fillers), 32'h00100713, 1'b1, 5'd14,
				64'(fillers + 1));
		end
		next_edge();
		check_count++;
		if (retire_ready !== 1'b0)
			log_error("retire_ready still high after trap");

		while (commits_seen < exp_pc.size())
			next_edge();
		@(posedge clock);
		commit_ready <= 1'b1;
		repeat (4) @(posedge clock);

		check_count++;
		if (instr_count !== count_t'(exp_pc.size()))
			log_error($sformatf("instr_count %0d, expected %0d", instr_count, exp_pc.size()));
		if (cycle_count !== frozen_cycles || cycle_count !== count_t'(run_edges)
				|| trap_valid !== 1'b1 || retire_ready !== 1'b0)
			log_error($sformatf("halt state lost, cycle_count %0d was %0d, expected %0d",
				cycle_count, frozen_cycles, run_edges));
		scan_registers(1'b1);

		$display("%0d checks, %0d errors, %0d of %0d commits seen",
			check_count, error_count, commits_seen, exp_pc.size());
		if (error_count == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: commit_top.f
commit_pkg.sv
commit_capture.sv
commit_fifo.sv
commit_tracker.sv
commit_top.sv
tb_commit_top.sv

// File: Makefile
# Verilator flow for the commit tracking path

SIM = obj_dir/Vtb_commit_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module commit_top -f commit_top.f

sim:
	verilator --binary --timing -Wno-fatal --top-module tb_commit_top -f commit_top.f
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir
